// ==== Bender.yml ====
package:
  name: core_complex

export_include_dirs:
  - .

sources:
  - core_complex_pkg.sv
  - mc_link_rx.sv
  - mc_router.sv
  - mc_endpoint.sv
  - mc_return_arbiter.sv
  - core_complex.sv
  - target: test
    files:
      - tb_core_complex.sv

// ==== core_complex.sv ====
`timescale 1ns/1ps
`include "mc_params.svh"

module core_complex
  import core_complex_pkg::*;
  (input                clk_i
  ,input                arst_n_i

  ,input                fwd_v_i
  ,input  mc_fwd_pkt_s  fwd_data_i
  ,output logic         fwd_token_o

  ,output logic         rev_v_o
  ,output mc_rev_pkt_s  rev_data_o
  ,input                rev_token_i
  );

  // receiver to router
  logic        req_v, req_ready;
  mc_fwd_pkt_s req_pkt;

  // router to endpoints
  logic [`MC_NUM_EP-1:0] ep_v, ep_ready;
  mc_fwd_pkt_s           ep_pkt;

  // endpoints to return arbiter
  logic        [`MC_NUM_EP-1:0] ret_v, ret_grant;
  mc_rev_pkt_s [`MC_NUM_EP-1:0] ret_pkt;

  mc_link_rx link_rx
  (.clk_i      (clk_i      )
  ,.arst_n_i   (arst_n_i   )
  ,.fwd_v_i    (fwd_v_i    )
  ,.fwd_data_i (fwd_data_i )
  ,.fwd_token_o(fwd_token_o)
  ,.req_v_o    (req_v      )
  ,.req_pkt_o  (req_pkt    )
  ,.req_ready_i(req_ready  )
  );

  mc_router router
  (.req_v_i    (req_v    )
  ,.req_pkt_i  (req_pkt  )
  ,.req_ready_o(req_ready)
  ,.ep_v_o     (ep_v     )
  ,.ep_pkt_o   (ep_pkt   )
  ,.ep_ready_i (ep_ready )
  );

  // west halfpod, tile and east halfpod reduced to scratchpad nodes
  for (genvar i = 0; i < `MC_NUM_EP; i++)
  begin: ep
    mc_endpoint
      #(.ep_x_p(`MC_EP_X_BASE + i))
    node
    (.clk_i      (clk_i       )
    ,.arst_n_i   (arst_n_i    )
    ,.req_v_i    (ep_v     [i])
    ,.req_pkt_i  (ep_pkt      )
    ,.req_ready_o(ep_ready [i])
    ,.ret_v_o    (ret_v    [i])
    ,.ret_pkt_o  (ret_pkt  [i])
    ,.ret_grant_i(ret_grant[i])
    );
  end

  mc_return_arbiter return_arb
  (.clk_i      (clk_i      )
  ,.arst_n_i   (arst_n_i   )
  ,.ret_v_i    (ret_v      )
  ,.ret_pkt_i  (ret_pkt    )
  ,.ret_grant_o(ret_grant  )
  ,.rev_v_o    (rev_v_o    )
  ,.rev_data_o (rev_data_o )
  ,.rev_token_i(rev_token_i)
  );

endmodule

// ==== core_complex_pkg.sv ====
`include "mc_params.svh"

package core_complex_pkg;

  // request opcode
  typedef enum logic
  {
    MC_OP_STORE = 1'b0,
    MC_OP_LOAD  = 1'b1
  } mc_op_e;

  // load view of the payload word
  typedef struct packed
  {
    logic [`MC_DATA_WIDTH-`MC_REG_ID_WIDTH-1:0] pad;
    logic [`MC_REG_ID_WIDTH-1:0]                reg_id;
  } mc_load_info_s;

  // store data or load info, chosen by op
  typedef union packed
  {
    logic [`MC_DATA_WIDTH-1:0] data;
    mc_load_info_s             load_info;
  } mc_payload_u;

  // host to row request
  typedef struct packed
  {
    mc_op_e                       op;
    logic [`MC_EP_ADDR_WIDTH-1:0] addr;
    mc_payload_u                  payload;
    logic [`MC_X_CORD_WIDTH-1:0]  src_x;
    logic [`MC_Y_CORD_WIDTH-1:0]  src_y;
    logic [`MC_X_CORD_WIDTH-1:0]  dst_x;
    logic [`MC_Y_CORD_WIDTH-1:0]  dst_y;
  } mc_fwd_pkt_s;

  // kind of return packet
  typedef enum logic
  {
    MC_REV_STORE_CREDIT = 1'b0,
    MC_REV_LOAD_DATA    = 1'b1
  } mc_rev_type_e;

  // row to host return, dst is the source of the request
  typedef struct packed
  {
    mc_rev_type_e                pkt_type;
    logic [`MC_REG_ID_WIDTH-1:0] reg_id;
    logic [`MC_DATA_WIDTH-1:0]   data;
    logic [`MC_X_CORD_WIDTH-1:0] src_x;
    logic [`MC_X_CORD_WIDTH-1:0] dst_x;
    logic [`MC_Y_CORD_WIDTH-1:0] dst_y;
  } mc_rev_pkt_s;

endpackage

// ==== flist.f ====
+incdir+.
core_complex_pkg.sv
mc_link_rx.sv
mc_router.sv
mc_endpoint.sv
mc_return_arbiter.sv
core_complex.sv
tb_core_complex.sv

// ==== mc_endpoint.sv ====
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_endpoint
  import core_complex_pkg::*;
  #(parameter int ep_x_p = `MC_EP_X_BASE)
  (input                clk_i
  ,input                arst_n_i

  ,input                req_v_i
  ,input  mc_fwd_pkt_s  req_pkt_i
  ,output logic         req_ready_o

  ,output logic         ret_v_o
  ,output mc_rev_pkt_s  ret_pkt_o
  ,input                ret_grant_i
  );

  localparam int words_lp = 2**`MC_EP_ADDR_WIDTH;

  logic [`MC_DATA_WIDTH-1:0] mem_r [words_lp];
  logic                      ret_v_r;
  mc_rev_pkt_s               ret_pkt_r;
  mc_rev_pkt_s               ret_next;
  logic                      accept;
  logic                      is_store;

  // slot frees up in the same cycle it is granted
  assign req_ready_o = ~ret_v_r | ret_grant_i;
  assign accept      = req_v_i & req_ready_o;
  assign is_store    = (req_pkt_i.op == MC_OP_STORE);

  assign ret_v_o   = ret_v_r;
  assign ret_pkt_o = ret_pkt_r;

  // return goes back to whoever sent the request
  always_comb
  begin
    ret_next       = '0;
    ret_next.src_x = `MC_X_CORD_WIDTH'(ep_x_p);
    ret_next.dst_x = req_pkt_i.src_x;
    ret_next.dst_y = req_pkt_i.src_y;
    if (is_store)
    begin
      ret_next.pkt_type = MC_REV_STORE_CREDIT;
    end
    else
    begin
      ret_next.pkt_type = MC_REV_LOAD_DATA;
      ret_next.reg_id   = req_pkt_i.payload.load_info.reg_id;
      ret_next.data     = mem_r[req_pkt_i.addr];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < words_lp; i++)
      begin
        mem_r[i] <= '0;
      end
    end
    else if (accept && is_store)
    begin
      mem_r[req_pkt_i.addr] <= req_pkt_i.payload.data;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ret_v_r <= 1'b0;
    end
    else if (accept)
    begin
      ret_v_r <= 1'b1;
    end
    else if (ret_grant_i)
    begin
      ret_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      ret_pkt_r <= ret_next;
    end
  end

endmodule

// ==== mc_link_rx.sv ====
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_link_rx
  import core_complex_pkg::*;
  (input                clk_i
  ,input                arst_n_i

  ,input                fwd_v_i
  ,input  mc_fwd_pkt_s  fwd_data_i
  ,output logic         fwd_token_o

  ,output logic         req_v_o
  ,output mc_fwd_pkt_s  req_pkt_o
  ,input                req_ready_i
  );

  localparam int depth_lp     = `MC_LINK_CREDITS;
  localparam int ptr_width_lp = $clog2(depth_lp);
  localparam int cnt_width_lp = $clog2(depth_lp+1);

  mc_fwd_pkt_s             fifo_mem [depth_lp];
  logic [ptr_width_lp-1:0] wr_ptr_r, rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    token_r;
  logic                    push, pop;

  // host never sends without a credit, so the fifo cannot overflow
  assign push = fwd_v_i;

  assign req_v_o   = (count_r != '0);
  assign req_pkt_o = fifo_mem[rd_ptr_r];
  assign pop       = req_v_o & req_ready_i;

  // each freed entry goes back to the host as one token cycle
  assign fwd_token_o = token_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      token_r  <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(depth_lp-1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(depth_lp-1)) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_width_lp'(push) - cnt_width_lp'(pop);
      token_r <= pop;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      fifo_mem[wr_ptr_r] <= fwd_data_i;
    end
  end

endmodule

// ==== mc_params.svh ====
`ifndef MC_PARAMS_SVH
`define MC_PARAMS_SVH

// data word carried in requests and returns
`define MC_DATA_WIDTH 32

// mesh coordinates
`define MC_X_CORD_WIDTH 2
`define MC_Y_CORD_WIDTH 2

// destination register of a load
`define MC_REG_ID_WIDTH 5

// word address inside one endpoint, 16 words
`define MC_EP_ADDR_WIDTH 4

// endpoints along the row, endpoint i sits at x = base + i
`define MC_NUM_EP 3
`define MC_EP_X_BASE 1

// y coordinate shared by every node of the row
`define MC_ROW_Y 1

// credits on the forward and the reverse link
`define MC_LINK_CREDITS 4

`endif

// ==== mc_return_arbiter.sv ====
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_return_arbiter
  import core_complex_pkg::*;
  (input                                  clk_i
  ,input                                  arst_n_i

  ,input        [`MC_NUM_EP-1:0]          ret_v_i
  ,input  mc_rev_pkt_s [`MC_NUM_EP-1:0]   ret_pkt_i
  ,output logic [`MC_NUM_EP-1:0]          ret_grant_o

  ,output logic                           rev_v_o
  ,output mc_rev_pkt_s                    rev_data_o
  ,input                                  rev_token_i
  );

  localparam int num_ep_lp       = `MC_NUM_EP;
  localparam int idx_width_lp    = (num_ep_lp > 1) ? $clog2(num_ep_lp) : 1;
  localparam int credit_width_lp = $clog2(`MC_LINK_CREDITS+1);

  logic [idx_width_lp-1:0]    last_r;
  logic [idx_width_lp-1:0]    grant_idx;
  logic [num_ep_lp-1:0]       grant;
  logic [credit_width_lp-1:0] credit_r;
  logic                       send;
  logic                       rev_v_r;
  mc_rev_pkt_s                rev_data_r;

  // search starts at the endpoint after the last one granted
  always_comb
  begin
    int idx;
    logic found;
    grant     = '0;
    grant_idx = last_r;
    found     = 1'b0;
    for (int k = 1; k <= num_ep_lp; k++)
    begin
      idx = (int'(last_r) + k) % num_ep_lp;
      if (!found && (credit_r != '0) && ret_v_i[idx])
      begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = idx_width_lp'(idx);
      end
    end
  end

  assign send        = |grant;
  assign ret_grant_o = grant;
  assign rev_v_o     = rev_v_r;
  assign rev_data_o  = rev_data_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      last_r   <= idx_width_lp'(num_ep_lp-1);
      credit_r <= credit_width_lp'(`MC_LINK_CREDITS);
      rev_v_r  <= 1'b0;
    end
    else
    begin
      if (send)
      begin
        last_r <= grant_idx;
      end
      // host token and a send in one cycle cancel out
      credit_r <= credit_r - credit_width_lp'(send) + credit_width_lp'(rev_token_i);
      rev_v_r  <= send;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (send)
    begin
      rev_data_r <= ret_pkt_i[grant_idx];
    end
  end

endmodule

// ==== mc_router.sv ====
`timescale 1ns/1ps
`include "mc_params.svh"

module mc_router
  import core_complex_pkg::*;
  (input                          req_v_i
  ,input  mc_fwd_pkt_s            req_pkt_i
  ,output logic                   req_ready_o

  ,output logic [`MC_NUM_EP-1:0]  ep_v_o
  ,output mc_fwd_pkt_s            ep_pkt_o
  ,input        [`MC_NUM_EP-1:0]  ep_ready_i
  );

  logic                  row_hit;
  logic [`MC_NUM_EP-1:0] ep_sel;

  assign row_hit = (req_pkt_i.dst_y == `MC_Y_CORD_WIDTH'(`MC_ROW_Y));

  // one-hot match of dst_x against the endpoint map
  always_comb
  begin
    ep_sel = '0;
    for (int i = 0; i < `MC_NUM_EP; i++)
    begin
      ep_sel[i] = row_hit && (req_pkt_i.dst_x == `MC_X_CORD_WIDTH'(`MC_EP_X_BASE + i));
    end
  end

  assign ep_v_o   = ep_sel & {`MC_NUM_EP{req_v_i}};
  assign ep_pkt_o = req_pkt_i;

  // stray packets are always accepted and silently dropped,
  // the receiver still hands their token back
  assign req_ready_o = (|ep_sel) ? |(ep_sel & ep_ready_i) : 1'b1;

endmodule

// ==== tb_core_complex.sv ====
`timescale 1ns/1ps
`include "mc_params.svh"

module tb_core_complex
  import core_complex_pkg::*;
  ();

  localparam int wait_limit_lp = 300;
  localparam int num_rows_lp   = 23;
  localparam int host_x_lp     = 0;
  localparam int host_y_lp     = 0;

  typedef struct packed
  {
    logic [3:0]                   test_id;
    mc_op_e                       op;
    logic [`MC_X_CORD_WIDTH-1:0]  dst_x;
    logic [`MC_Y_CORD_WIDTH-1:0]  dst_y;
    logic [`MC_EP_ADDR_WIDTH-1:0] addr;
    logic [`MC_DATA_WIDTH-1:0]    word;
    logic                         hold;
  } stim_row_s;

  logic        clk_i;
  logic        arst_n_i    = 1'b0;
  logic        fwd_v_i     = 1'b0;
  mc_fwd_pkt_s fwd_data_i  = '0;
  logic        rev_token_i = 1'b0;
  logic        fwd_token_o;
  logic        rev_v_o;
  mc_rev_pkt_s rev_data_o;

  stim_row_s                 rows [num_rows_lp];
  logic [`MC_DATA_WIDTH-1:0] ref_mem [`MC_NUM_EP][2**`MC_EP_ADDR_WIDTH];
  mc_rev_pkt_s               exp_q [`MC_NUM_EP][$];

  int   pkts_sent    = 0;
  int   tokens_seen  = 0;
  int   rev_seen     = 0;
  int   tok_returned = 0;
  int   errors       = 0;
  int   checks       = 0;
  int   tests_failed = 0;
  bit   hold_tokens  = 1'b0;
  bit   timed_out    = 1'b0;
  logic [31:0] rng_state = 32'ha2fb_8863;
  int   token_delay  = 0;

  core_complex core_complex_i
  (.clk_i      (clk_i      )
  ,.arst_n_i   (arst_n_i   )
  ,.fwd_v_i    (fwd_v_i    )
  ,.fwd_data_i (fwd_data_i )
  ,.fwd_token_o(fwd_token_o)
  ,.rev_v_o    (rev_v_o    )
  ,.rev_data_o (rev_data_o )
  ,.rev_token_i(rev_token_i)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic stim_row_s make_row(input int id, input mc_op_e op, input int x,
                                         input int y, input int addr,
                                         input logic [31:0] word, input bit hold);
    stim_row_s r;
    r.test_id = 4'(id);
    r.op      = op;
    r.dst_x   = `MC_X_CORD_WIDTH'(x);
    r.dst_y   = `MC_Y_CORD_WIDTH'(y);
    r.addr    = `MC_EP_ADDR_WIDTH'(addr);
    r.word    = word;
    r.hold    = hold;
    return r;
  endfunction

  // each row holds test, op, dst_x, dst_y, addr, store data or load reg_id and the hold flag
  task automatic fill_table();
    rows[0]  = make_row(2, MC_OP_STORE, 1, 1, 3, 32'hdead_beef, 0);
    rows[1]  = make_row(2, MC_OP_LOAD,  1, 1, 3, 32'd7,         0);
    rows[2]  = make_row(3, MC_OP_STORE, 1, 1, 5, 32'h1111_0001, 0);
    rows[3]  = make_row(3, MC_OP_STORE, 2, 1, 5, 32'h2222_0002, 0);
    rows[4]  = make_row(3, MC_OP_STORE, 3, 1, 5, 32'h3333_0003, 0);
    rows[5]  = make_row(3, MC_OP_LOAD,  3, 1, 5, 32'd3,         0);
    rows[6]  = make_row(3, MC_OP_LOAD,  1, 1, 5, 32'd1,         0);
    rows[7]  = make_row(3, MC_OP_LOAD,  2, 1, 5, 32'd2,         0);
    rows[8]  = make_row(3, MC_OP_STORE, 2, 1, 5, 32'h4444_0004, 0);
    rows[9]  = make_row(3, MC_OP_LOAD,  2, 1, 5, 32'd9,         0);
    rows[10] = make_row(4, MC_OP_STORE, 0, 1, 5, 32'hbad0_0000, 0);
    rows[11] = make_row(4, MC_OP_STORE, 2, 2, 5, 32'hbad0_0001, 0);
    rows[12] = make_row(4, MC_OP_LOAD,  2, 1, 5, 32'd4,         0);
    rows[13] = make_row(5, MC_OP_STORE, 1, 1, 0, 32'hcafe_0001, 0);
    rows[14] = make_row(5, MC_OP_STORE, 2, 1, 1, 32'hcafe_0002, 0);
    rows[15] = make_row(5, MC_OP_LOAD,  1, 1, 0, 32'd10,        0);
    rows[16] = make_row(5, MC_OP_LOAD,  2, 1, 1, 32'd11,        0);
    rows[17] = make_row(6, MC_OP_STORE, 3, 1, 7, 32'h5555_0005, 1);
    rows[18] = make_row(6, MC_OP_LOAD,  3, 1, 7, 32'd13,        1);
    rows[19] = make_row(6, MC_OP_STORE, 1, 1, 9, 32'h6666_0006, 1);
    rows[20] = make_row(6, MC_OP_LOAD,  1, 1, 9, 32'd14,        1);
    rows[21] = make_row(6, MC_OP_LOAD,  2, 1, 5, 32'd12,        1);
    rows[22] = make_row(6, MC_OP_LOAD,  3, 1, 7, 32'd15,        1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_return(input mc_rev_pkt_s got);
    int          idx;
    mc_rev_pkt_s exp;
    idx = int'(got.src_x) - `MC_EP_X_BASE;
    checks++;
    assert ((idx >= 0) && (idx < `MC_NUM_EP) && (exp_q[idx].size() > 0))
    else
    begin
      $display("Error %0t return from x=%0d arrived with nothing expected", $time, got.src_x);
      errors++;
    end
    if ((idx >= 0) && (idx < `MC_NUM_EP) && (exp_q[idx].size() > 0))
    begin
      exp = exp_q[idx].pop_front();
      check_val("rev_data_o.pkt_type", 32'(got.pkt_type), 32'(exp.pkt_type));
      check_val("rev_data_o.dst_x", 32'(got.dst_x), 32'(exp.dst_x));
      check_val("rev_data_o.dst_y", 32'(got.dst_y), 32'(exp.dst_y));
      if (exp.pkt_type == MC_REV_LOAD_DATA)
      begin
        check_val("rev_data_o.reg_id", 32'(got.reg_id), 32'(exp.reg_id));
        check_val("rev_data_o.data", got.data, exp.data);
      end
    end
  endtask

  // registered outputs are sampled before the edge updates them
  always @(posedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (fwd_token_o)
      begin
        tokens_seen++;
      end
      if (rev_v_o)
      begin
        rev_seen++;
        check_return(rev_data_o);
      end
      checks++;
      assert (rev_seen - tok_returned <= `MC_LINK_CREDITS)
      else
      begin
        $display("Error %0t reverse link sent %0d packets with only %0d tokens returned",
                 $time, rev_seen, tok_returned);
        errors++;
      end
    end
  end

  // host returns one reverse token per received packet after a random delay
  always @(negedge clk_i)
  begin
    rev_token_i = 1'b0;
    if (arst_n_i && !hold_tokens && (rev_seen > tok_returned))
    begin
      if (token_delay == 0)
      begin
        rev_token_i = 1'b1;
        tok_returned++;
        rng_state   = next_rand(rng_state);
        token_delay = int'(rng_state % 4);
      end
      else
      begin
        token_delay--;
      end
    end
  end

  task automatic send_row(input stim_row_s row);
    mc_fwd_pkt_s pkt;
    mc_rev_pkt_s exp;
    int          ep;
    int          waited;
    waited = 0;
    while (!timed_out && (`MC_LINK_CREDITS - pkts_sent + tokens_seen <= 0))
    begin
      @(negedge clk_i);
      waited++;
      if (waited > wait_limit_lp)
      begin
        $display("Error %0t timed out waiting for a forward link credit", $time);
        timed_out = 1'b1;
      end
    end
    if (!timed_out)
    begin
      pkt         = '0;
      pkt.op      = row.op;
      pkt.addr    = row.addr;
      pkt.src_x   = `MC_X_CORD_WIDTH'(host_x_lp);
      pkt.src_y   = `MC_Y_CORD_WIDTH'(host_y_lp);
      pkt.dst_x   = row.dst_x;
      pkt.dst_y   = row.dst_y;
      if (row.op == MC_OP_STORE)
      begin
        pkt.payload.data = row.word;
      end
      else
      begin
        pkt.payload.load_info.reg_id = row.word[`MC_REG_ID_WIDTH-1:0];
      end
      // packets outside the row expect no return
      ep = int'(row.dst_x) - `MC_EP_X_BASE;
      if ((row.dst_y == `MC_Y_CORD_WIDTH'(`MC_ROW_Y)) && (ep >= 0) && (ep < `MC_NUM_EP))
      begin
        exp       = '0;
        exp.src_x = row.dst_x;
        exp.dst_x = `MC_X_CORD_WIDTH'(host_x_lp);
        exp.dst_y = `MC_Y_CORD_WIDTH'(host_y_lp);
        if (row.op == MC_OP_STORE)
        begin
          exp.pkt_type          = MC_REV_STORE_CREDIT;
          ref_mem[ep][row.addr] = row.word;
        end
        else
        begin
          exp.pkt_type = MC_REV_LOAD_DATA;
          exp.reg_id   = row.word[`MC_REG_ID_WIDTH-1:0];
          exp.data     = ref_mem[ep][row.addr];
        end
        exp_q[ep].push_back(exp);
      end
      fwd_v_i    = 1'b1;
      fwd_data_i = pkt;
      pkts_sent++;
      @(negedge clk_i);
      fwd_v_i = 1'b0;
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (!timed_out && ((exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0)
           || (tokens_seen < pkts_sent) || (rev_seen != tok_returned)))
    begin
      @(negedge clk_i);
      waited++;
      if (waited > wait_limit_lp)
      begin
        $display("Error %0t timed out waiting for returns and tokens to drain", $time);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic wait_rev_stalled();
    int waited;
    waited = 0;
    while (!timed_out && (rev_seen - tok_returned < `MC_LINK_CREDITS))
    begin
      @(negedge clk_i);
      waited++;
      if (waited > wait_limit_lp)
      begin
        $display("Error %0t reverse link never used up its credit", $time);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic report_test(input int id, input string name, input int errs_before);
    if ((errors == errs_before) && !timed_out)
    begin
      $display("test %0d %s: ok", id, name);
    end
    else
    begin
      $display("test %0d %s: FAILED", id, name);
      tests_failed++;
    end
  endtask

  task automatic run_table_test(input int id, input string name);
    int errs_before;
    errs_before = errors;
    for (int r = 0; r < num_rows_lp; r++)
    begin
      if ((int'(rows[r].test_id) == id) && !timed_out)
      begin
        if (rows[r].hold && !hold_tokens)
        begin
          @(posedge clk_i);
          hold_tokens = 1'b1;
          @(negedge clk_i);
        end
        send_row(rows[r]);
      end
    end
    if (hold_tokens)
    begin
      wait_rev_stalled();
      @(posedge clk_i);
      hold_tokens = 1'b0;
      @(negedge clk_i);
    end
    wait_drained();
    check_val("fwd_token_o pulses", 32'(tokens_seen), 32'(pkts_sent));
    report_test(id, name, errs_before);
  endtask

  initial
  begin
    int    errs_before;
    string names [2:6];
    names[2] = "store then load";
    names[3] = "independent endpoints";
    names[4] = "stray packets";
    names[5] = "back to back on full credit";
    names[6] = "withheld reverse tokens";
    for (int e = 0; e < `MC_NUM_EP; e++)
    begin
      for (int a = 0; a < 2**`MC_EP_ADDR_WIDTH; a++)
      begin
        ref_mem[e][a] = '0;
      end
    end
    fill_table();

    errs_before = errors;
    for (int c = 0; c < 2; c++)
    begin
      @(negedge clk_i);
      check_val("rev_v_o", 32'(rev_v_o), 32'd0);
      check_val("fwd_token_o", 32'(fwd_token_o), 32'd0);
    end
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_val("rev_v_o", 32'(rev_v_o), 32'd0);
    check_val("fwd_token_o", 32'(fwd_token_o), 32'd0);
    report_test(1, "reset state", errs_before);

    for (int t = 2; t <= 6; t++)
    begin
      run_table_test(t, names[t]);
    end

    $display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
    if ((errors == 0) && !timed_out)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
